// File: common/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5,  // signed compare.
        alu_sll = 3'd6,
        alu_lui = 3'd7   // b shifted up by 16 for an upper immediate.
    } alu_op_t;

    // a decoded operation as it enters the back end.
    typedef struct packed {
        logic [31:0] pc;
        alu_op_t     alu_op;
        logic [4:0]  src1;
        logic [4:0]  src2;
        logic        use_imm;
        logic [31:0] imm;
        logic [4:0]  dest;
        logic        gr_we;
        logic        mem_re;
        logic        mem_we;
    } op_t;

    typedef struct packed {
        logic        res_from_mem;  // 70
        logic        gr_we;         // 69
        logic [4:0]  dest;          // 68:64
        logic [31:0] alu_result;    // 63:32
        logic [31:0] pc;            // 31:0
    } es_to_ms_t;

    typedef struct packed {
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] final_result;
        logic [31:0] pc;
    } ms_to_ws_t;

    // one forwarding source seen by execute.
    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic [31:0] value;
    } fwd_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] value;
    } commit_t;

endpackage

// File: source/pipe_valid_reg.sv
module pipe_valid_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     out_allowin,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;
    logic     ready_go;

    // the stage never waits on anything of its own.
    assign ready_go = 1'b1;

    // empty, or the held entry leaves in this same cycle.
    assign in_allowin = !valid_q || (ready_go && out_allowin);
    assign out_valid  = valid_q && ready_go;
    assign out_data   = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            data_q <= in_data;  // only on a transfer.
        end
    end

endmodule

// File: source/regfile.sv
module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // register 0 always reads back as zero.
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = 32'd0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == 5'd0) begin
            rdata2 = 32'd0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// File: source/data_ram.sv
module data_ram #(
    parameter int ram_addr_width = 8
) (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      we,
    input  logic [ram_addr_width-1:0] addr,
    input  logic [31:0]               wdata,
    output logic [31:0]               rdata
);

    localparam int depth = 1 << ram_addr_width;

    logic [31:0] mem [0:depth-1];
    logic [31:0] rdata_q;

    // rdata_q only changes on an enabled read, so a stalled
    // memory stage keeps seeing its own load data.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata_q <= mem[addr];
            end
        end
    end

    assign rdata = rdata_q;

endmodule

// File: execute/alu.sv
module alu (
    input  cpu_pkg::alu_op_t op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      result
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        lt;

    assign sum  = a + b;
    assign diff = a - b;
    assign lt   = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpu_pkg::alu_add: begin
                result = sum;
            end
            cpu_pkg::alu_sub: begin
                result = diff;
            end
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or:  result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_slt: begin
                result = {31'd0, lt};
            end
            cpu_pkg::alu_sll: begin
                result = a << b[4:0];  // only the low five bits count.
            end
            cpu_pkg::alu_lui: begin
                result = b << 16;
            end
            default: begin
                result = 32'd0;
            end
        endcase
    end

endmodule

// File: execute/exe_stage.sv
module exe_stage #(
    parameter int ram_addr_width = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  cpu_pkg::op_t              in_op,
    output logic                      in_allowin,
    input  logic                      ms_allowin,
    output logic                      es_to_ms_valid,
    output cpu_pkg::es_to_ms_t        es_to_ms,
    output logic [4:0]                rf_raddr1,
    output logic [4:0]                rf_raddr2,
    input  logic [31:0]               rf_rdata1,
    input  logic [31:0]               rf_rdata2,
    input  cpu_pkg::fwd_t             ms_fwd,
    input  cpu_pkg::fwd_t             ws_fwd,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [ram_addr_width-1:0] ram_addr,
    output logic [31:0]               ram_wdata
);

    logic         es_valid;
    cpu_pkg::op_t es_op;
    logic         es_go;
    logic [31:0]  src1_val;
    logic [31:0]  src2_val;
    logic [31:0]  alu_b;
    logic [31:0]  alu_result;

    // memory wins over write-back and both win over the register file.
    function automatic logic [31:0] resolve(input logic [4:0] src, input logic [31:0] rf_val,
                                            input cpu_pkg::fwd_t mf, input cpu_pkg::fwd_t wf);
        logic [31:0] val;
        val = rf_val;
        if (src != 5'd0) begin
            if (mf.valid && mf.dest == src) begin
                val = mf.value;
            end else if (wf.valid && wf.dest == src) begin
                val = wf.value;
            end
        end
        return val;
    endfunction

    assign in_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_go          = es_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_op <= in_op;
        end
    end

    assign rf_raddr1 = es_op.src1;
    assign rf_raddr2 = es_op.src2;
    assign src1_val  = resolve(es_op.src1, rf_rdata1, ms_fwd, ws_fwd);
    assign src2_val  = resolve(es_op.src2, rf_rdata2, ms_fwd, ws_fwd);
    assign alu_b     = es_op.use_imm ? es_op.imm : src2_val;

    alu alu0 (
        .op     (es_op.alu_op),
        .a      (src1_val),
        .b      (alu_b),
        .result (alu_result)
    );

    assign es_to_ms = '{res_from_mem: es_op.mem_re, gr_we: es_op.gr_we, dest: es_op.dest,
                        alu_result: alu_result, pc: es_op.pc};

    // the access goes out only as the operation moves to memory.
    assign ram_en    = es_go;
    assign ram_we    = es_go && es_op.mem_we;
    assign ram_addr  = alu_result[ram_addr_width+1:2];  // word address.
    assign ram_wdata = src2_val;

endmodule

// File: source/mem_stage.sv
module mem_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               es_to_ms_valid,
    input  cpu_pkg::es_to_ms_t es_to_ms,
    output logic               ms_allowin,
    input  logic               ws_allowin,
    output logic               ms_to_ws_valid,
    output cpu_pkg::ms_to_ws_t ms_to_ws,
    input  logic [31:0]        ram_rdata,
    output cpu_pkg::fwd_t      ms_fwd
);

    logic               ms_valid;
    cpu_pkg::es_to_ms_t ms_op;
    logic [31:0]        final_result;

    pipe_valid_reg #(
        .payload_t (cpu_pkg::es_to_ms_t)
    ) ms_reg (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (es_to_ms_valid),
        .in_data     (es_to_ms),
        .out_allowin (ws_allowin),
        .in_allowin  (ms_allowin),
        .out_valid   (ms_valid),
        .out_data    (ms_op)
    );

    // load data arrive this cycle from the access issued in execute.
    assign final_result = ms_op.res_from_mem ? ram_rdata : ms_op.alu_result;

    assign ms_to_ws_valid = ms_valid;

    always_comb begin
        ms_to_ws.gr_we        = ms_op.gr_we;
        ms_to_ws.dest         = ms_op.dest;
        ms_to_ws.final_result = final_result;
        ms_to_ws.pc           = ms_op.pc;
    end

    // loads forward their data too, so a dependent op never waits.
    always_comb begin
        ms_fwd.valid = ms_valid && ms_op.gr_we;
        ms_fwd.dest  = ms_op.dest;
        ms_fwd.value = final_result;
    end

endmodule

// File: source/wb_stage.sv
module wb_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t ms_to_ws,
    output logic               ws_allowin,
    output logic               commit_valid,
    output cpu_pkg::commit_t   commit,
    input  logic               commit_ready,
    output logic               rf_we,
    output logic [4:0]         rf_waddr,
    output logic [31:0]        rf_wdata,
    output cpu_pkg::fwd_t      ws_fwd
);

    logic               ws_valid;
    cpu_pkg::ms_to_ws_t ws_op;

    pipe_valid_reg #(
        .payload_t (cpu_pkg::ms_to_ws_t)
    ) ws_reg (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (ms_to_ws_valid),
        .in_data     (ms_to_ws),
        .out_allowin (commit_ready),  // the commit port acts as the next stage.
        .in_allowin  (ws_allowin),
        .out_valid   (ws_valid),
        .out_data    (ws_op)
    );

    assign commit_valid = ws_valid;
    assign commit = '{pc: ws_op.pc, gr_we: ws_op.gr_we, dest: ws_op.dest,
                      value: ws_op.final_result};

    // the register file only sees a result once it has retired.
    assign rf_we    = ws_valid && commit_ready && ws_op.gr_we;
    assign rf_waddr = ws_op.dest;
    assign rf_wdata = ws_op.final_result;

    assign ws_fwd = '{valid: ws_valid && ws_op.gr_we, dest: ws_op.dest,
                      value: ws_op.final_result};

endmodule

// File: source/cpu_backend.sv
module cpu_backend #(
    parameter int ram_addr_width = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  cpu_pkg::op_t     in_op,
    output logic             in_allowin,
    output logic             commit_valid,
    output cpu_pkg::commit_t commit,
    input  logic             commit_ready
);

    logic                      es_to_ms_valid;
    cpu_pkg::es_to_ms_t        es_to_ms;
    logic                      ms_allowin;
    logic                      ms_to_ws_valid;
    cpu_pkg::ms_to_ws_t        ms_to_ws;
    logic                      ws_allowin;
    cpu_pkg::fwd_t             ms_fwd;
    cpu_pkg::fwd_t             ws_fwd;
    logic [4:0]                rf_raddr1;
    logic [4:0]                rf_raddr2;
    logic [31:0]               rf_rdata1;
    logic [31:0]               rf_rdata2;
    logic                      rf_we;
    logic [4:0]                rf_waddr;
    logic [31:0]               rf_wdata;
    logic                      ram_en;
    logic                      ram_we;
    logic [ram_addr_width-1:0] ram_addr;
    logic [31:0]               ram_wdata;
    logic [31:0]               ram_rdata;

    exe_stage #(
        .ram_addr_width (ram_addr_width)
    ) exe0 (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_allowin     (in_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms       (es_to_ms),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    mem_stage mem0 (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms       (es_to_ms),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws       (ms_to_ws),
        .ram_rdata      (ram_rdata),
        .ms_fwd         (ms_fwd)
    );

    wb_stage wb0 (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws       (ms_to_ws),
        .ws_allowin     (ws_allowin),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .ws_fwd         (ws_fwd)
    );

    regfile rf0 (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    data_ram #(
        .ram_addr_width (ram_addr_width)
    ) ram0 (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// File: verification/tb_clock.sv
module tb_clock #(
    parameter int period       = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;  // released just after an edge like the other inputs.
    end

endmodule

// File: verification/cpu_backend_tb.sv
module cpu_backend_tb;

    localparam int ram_addr_width = 8;
    localparam int n_ops          = 24;
    localparam int warm_len       = 16;
    localparam int burst_at       = 18;
    localparam int burst_len      = 5;
    localparam int timeout_cycles = n_ops * 8 + 20;

    // one row of the table holds the operation and the value it must commit.
    typedef struct packed {
        cpu_pkg::op_t op;
        logic [31:0]  expected;
    } table_entry_t;

    logic             clk;
    logic             reset;
    logic             in_valid;
    cpu_pkg::op_t     in_op;
    logic             in_allowin;
    logic             commit_valid;
    cpu_pkg::commit_t commit;
    logic             commit_ready;

    table_entry_t     op_table [0:n_ops-1];
    cpu_pkg::commit_t exp_q [$];
    logic [31:0]      model_rf [0:31];
    logic [31:0]      model_mem [0:(1 << ram_addr_width)-1];
    logic [31:0]      rng_state;
    int               cycle_count = 0;
    int               n_accepted = 0;
    int               n_commits = 0;

    tb_clock #(
        .period       (20),
        .reset_cycles (2)
    ) clock0 (
        .clk   (clk),
        .reset (reset)
    );

    cpu_backend #(
        .ram_addr_width (ram_addr_width)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_allowin   (in_allowin),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic cpu_pkg::op_t rr_op(input cpu_pkg::alu_op_t alu_op, input logic [4:0] dest,
                                           input logic [4:0] src1, input logic [4:0] src2);
        cpu_pkg::op_t op;
        op        = '0;
        op.alu_op = alu_op;
        op.src1   = src1;
        op.src2   = src2;
        op.dest   = dest;
        op.gr_we  = 1'b1;
        return op;
    endfunction

    function automatic cpu_pkg::op_t ri_op(input cpu_pkg::alu_op_t alu_op, input logic [4:0] dest,
                                           input logic [4:0] src1, input logic [31:0] imm);
        cpu_pkg::op_t op;
        op         = rr_op(alu_op, dest, src1, 5'd0);
        op.use_imm = 1'b1;
        op.imm     = imm;
        return op;
    endfunction

    function automatic cpu_pkg::op_t lw_op(input logic [4:0] dest, input logic [4:0] base,
                                           input logic [31:0] offset);
        cpu_pkg::op_t op;
        op        = ri_op(cpu_pkg::alu_add, dest, base, offset);
        op.mem_re = 1'b1;
        return op;
    endfunction

    // a store writes no register; its commit value is the address.
    function automatic cpu_pkg::op_t sw_op(input logic [4:0] data, input logic [4:0] base,
                                           input logic [31:0] offset);
        cpu_pkg::op_t op;
        op        = ri_op(cpu_pkg::alu_add, 5'd0, base, offset);
        op.src2   = data;
        op.gr_we  = 1'b0;
        op.mem_we = 1'b1;
        return op;
    endfunction

    task automatic load_table();
        op_table[0]  = '{op: ri_op(cpu_pkg::alu_lui, 5'd1, 5'd0, 32'h8000), expected: 32'h80000000};
        op_table[1]  = '{op: ri_op(cpu_pkg::alu_add, 5'd2, 5'd0, 32'h25), expected: 32'h25};
        op_table[2]  = '{op: ri_op(cpu_pkg::alu_add, 5'd3, 5'd2, 32'h10), expected: 32'h35};
        op_table[3]  = '{op: rr_op(cpu_pkg::alu_sub, 5'd4, 5'd3, 5'd2), expected: 32'h10};
        op_table[4]  = '{op: rr_op(cpu_pkg::alu_or, 5'd5, 5'd1, 5'd4), expected: 32'h80000010};
        op_table[5]  = '{op: rr_op(cpu_pkg::alu_slt, 5'd6, 5'd1, 5'd2), expected: 32'h1};
        op_table[6]  = '{op: rr_op(cpu_pkg::alu_slt, 5'd7, 5'd2, 5'd1), expected: 32'h0};
        op_table[7]  = '{op: ri_op(cpu_pkg::alu_xor, 5'd8, 5'd5, 32'hffff), expected: 32'h8000ffef};
        op_table[8]  = '{op: rr_op(cpu_pkg::alu_and, 5'd9, 5'd8, 5'd3), expected: 32'h25};
        op_table[9]  = '{op: rr_op(cpu_pkg::alu_sll, 5'd10, 5'd2, 5'd3), expected: 32'h04a00000};
        op_table[10] = '{op: rr_op(cpu_pkg::alu_add, 5'd0, 5'd2, 5'd3), expected: 32'h5a};
        op_table[11] = '{op: rr_op(cpu_pkg::alu_add, 5'd11, 5'd0, 5'd2), expected: 32'h25};
        op_table[12] = '{op: sw_op(5'd5, 5'd0, 32'h40), expected: 32'h40};
        op_table[13] = '{op: lw_op(5'd12, 5'd0, 32'h40), expected: 32'h80000010};
        op_table[14] = '{op: rr_op(cpu_pkg::alu_add, 5'd13, 5'd12, 5'd2), expected: 32'h80000035};
        op_table[15] = '{op: sw_op(5'd13, 5'd4, 32'h34), expected: 32'h44};
        op_table[16] = '{op: lw_op(5'd14, 5'd0, 32'h44), expected: 32'h80000035};
        op_table[17] = '{op: ri_op(cpu_pkg::alu_sll, 5'd15, 5'd14, 32'h4), expected: 32'h350};
        op_table[18] = '{op: sw_op(5'd15, 5'd0, 32'h48), expected: 32'h48};
        op_table[19] = '{op: lw_op(5'd16, 5'd0, 32'h48), expected: 32'h350};
        op_table[20] = '{op: rr_op(cpu_pkg::alu_slt, 5'd17, 5'd16, 5'd1), expected: 32'h0};
        op_table[21] = '{op: ri_op(cpu_pkg::alu_lui, 5'd18, 5'd0, 32'hfffe), expected: 32'hfffe0000};
        op_table[22] = '{op: rr_op(cpu_pkg::alu_slt, 5'd19, 5'd18, 5'd16), expected: 32'h1};
        op_table[23] = '{op: rr_op(cpu_pkg::alu_xor, 5'd20, 5'd19, 5'd18), expected: 32'hfffe0001};
        for (int i = 0; i < n_ops; i++) begin
            op_table[i].op.pc = 32'h1000 + 32'(i * 4);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, want));
        end
    endtask

    // executes one accepted operation in order and queues its commit.
    task automatic model_step(input cpu_pkg::op_t op);
        logic [31:0]               a;
        logic [31:0]               b;
        logic [31:0]               res;
        logic [31:0]               value;
        logic [ram_addr_width-1:0] widx;
        cpu_pkg::commit_t          c;
        a = model_rf[op.src1];
        b = op.use_imm ? op.imm : model_rf[op.src2];
        case (op.alu_op)
            cpu_pkg::alu_add: res = a + b;
            cpu_pkg::alu_sub: res = a - b;
            cpu_pkg::alu_and: res = a & b;
            cpu_pkg::alu_or:  res = a | b;
            cpu_pkg::alu_xor: res = a ^ b;
            cpu_pkg::alu_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::alu_sll: res = a << b[4:0];
            cpu_pkg::alu_lui: res = {b[15:0], 16'h0000};
            default:          res = 32'd0;
        endcase
        widx  = res[ram_addr_width+1:2];
        value = op.mem_re ? model_mem[widx] : res;
        if (op.mem_we) begin
            model_mem[widx] = model_rf[op.src2];
        end
        if (op.gr_we && op.dest != 5'd0) begin
            model_rf[op.dest] = value;  // register 0 stays zero.
        end
        c.pc    = op.pc;
        c.gr_we = op.gr_we;
        c.dest  = op.dest;
        c.value = value;
        exp_q.push_back(c);
    endtask

    task automatic check_commit();
        cpu_pkg::commit_t want;
        assert (exp_q.size() > 0) else begin
            report_failure("a commit arrived while no operation was outstanding");
        end
        want = exp_q.pop_front();
        check_value("commit.pc", commit.pc, want.pc);
        check_value("commit.gr_we", 32'(commit.gr_we), 32'(want.gr_we));
        check_value("commit.dest", 32'(commit.dest), 32'(want.dest));
        check_value("commit.value", commit.value, want.value);
        check_value("commit.value", commit.value, op_table[n_commits].expected);
        n_commits++;
    endtask

    always @(posedge clk) begin
        if (cycle_count >= timeout_cycles) begin
            report_failure($sformatf("timeout after %0d cycles, the pipeline stopped committing",
                                     cycle_count));
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        logic [31:0] rnd;
        logic        offering;
        logic        saw_stall;
        logic        seen_commit;
        logic        burst_done;
        int          burst;
        int          edge_count;
        int          first_accept_edge;
        in_valid          = 1'b0;
        in_op             = '0;
        commit_ready      = 1'b0;
        rng_state         = 32'hfc88a704;
        offering          = 1'b0;
        saw_stall         = 1'b0;
        seen_commit       = 1'b0;
        burst_done        = 1'b0;
        burst             = 0;
        edge_count        = 0;
        first_accept_edge = 0;
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = 32'd0;
        end
        load_table();

        // the stage valids are cleared by the first edge under reset.
        @(posedge clk);
        @(negedge clk);
        while (reset) begin
            check_value("commit_valid", 32'(commit_valid), 32'd0);
            @(negedge clk);
        end
        check_value("in_allowin", 32'(in_allowin), 32'd1);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        @(posedge clk);
        #1;

        while (n_commits < n_ops) begin
            rnd = next_random();
            if (!burst_done && n_accepted >= burst_at) begin
                burst      = burst_len;  // a forced stall that fills the pipeline.
                burst_done = 1'b1;
            end
            if (!offering) begin
                if (n_accepted < n_ops &&
                    (n_accepted < warm_len || burst > 0 || rnd[28:27] != 2'd0)) begin
                    in_valid = 1'b1;
                    in_op    = op_table[n_accepted].op;
                    offering = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            if (n_accepted < warm_len) begin
                commit_ready = 1'b1;
            end else if (burst > 0) begin
                commit_ready = 1'b0;
                burst--;
            end else begin
                commit_ready = (rnd[31:29] >= 3'd3);
            end

            @(negedge clk);
            if (!in_allowin) begin
                saw_stall = 1'b1;
                // only a full pipeline behind a held commit may refuse input.
                check_value("commit_valid", 32'(commit_valid), 32'd1);
                check_value("commit_ready", 32'(commit_ready), 32'd0);
            end
            if (in_valid && in_allowin) begin
                model_step(in_op);
                if (n_accepted == 0) begin
                    first_accept_edge = edge_count + 1;
                end
                n_accepted++;
                offering = 1'b0;
            end
            if (commit_valid && !seen_commit) begin
                seen_commit = 1'b1;
                check_value("first commit latency", edge_count - first_accept_edge, 32'd2);
            end
            if (seen_commit && n_commits < warm_len) begin
                check_value("commit_valid", 32'(commit_valid), 32'd1);  // no bubbles.
            end
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            @(posedge clk);
            edge_count++;
            #1;
        end

        in_valid     = 1'b0;
        commit_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("commit_valid", 32'(commit_valid), 32'd0);
        end

        if (exp_q.size() == 0 && saw_stall) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure($sformatf("run ended with %0d commits outstanding, stall seen %0d",
                                     exp_q.size(), saw_stall));
        end
    end

endmodule

// File: cpu_backend.f
common/cpu_pkg.sv
source/pipe_valid_reg.sv
source/regfile.sv
source/data_ram.sv
execute/alu.sv
execute/exe_stage.sv
source/mem_stage.sv
source/wb_stage.sv
source/cpu_backend.sv
verification/tb_clock.sv
verification/cpu_backend_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_backend_tb
FILELIST  = cpu_backend.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status of the simulator is the result of the run.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
